// ==== vlog.f ====
+incdir+.
gpu_types_pkg.sv
warp_ctl_pkg.sv
gpu_unit.sv
warp_mask_table.sv
barrier_table.sv
warp_sched.sv
gpu_ctl_top.sv
tb_clk_gen.sv
tb_checker.sv
tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_top.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module tb_top import gpu_types_pkg::*; ();

    localparam int NUM_ROWS    = 12;
    // a row takes about ten cycles at the longest stall run
    localparam int CYCLE_LIMIT = NUM_ROWS * 20;

    typedef struct packed {
        logic [127:0]                  name;
        logic [`NW_BITS-1:0]           wid;
        gpu_op_e                       op;
        logic [`NUM_THREADS-1:0]       tmask;
        logic [`NUM_THREADS-1:0][31:0] rs1;
        logic [31:0]                   rs2;
        logic [31:0]                   pc;
        logic [31:0]                   next_pc;
    } row_t;

    row_t                    rows [NUM_ROWS];
    logic                    clk;
    logic                    rst_n;
    gpu_req_t                req;
    logic                    req_ready;
    gpu_commit_t             commit;
    logic                    commit_ready = 1'b1;
    logic [`NUM_WARPS-1:0]   schedulable;
    logic                    sched_valid;
    logic [`NW_BITS-1:0]     sched_wid;
    logic [`NUM_THREADS-1:0] sched_tmask;
    logic [31:0]             sched_pc;
    logic [127:0]            cur_name;
    logic [15:0]             lfsr = 16'd35419;
    logic [1:0]              ready_bits;
    int                      cycles = 0;
    int                      tests_done;
    int                      error_count;
    int                      pending;

    tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    gpu_ctl_top i_gpu_ctl_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_ready    (req_ready),
        .commit       (commit),
        .commit_ready (commit_ready),
        .schedulable  (schedulable),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_tmask  (sched_tmask),
        .sched_pc     (sched_pc)
    );

    tb_checker i_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_ready    (req_ready),
        .commit       (commit),
        .commit_ready (commit_ready),
        .schedulable  (schedulable),
        .sched_valid  (sched_valid),
        .sched_wid    (sched_wid),
        .sched_tmask  (sched_tmask),
        .sched_pc     (sched_pc),
        .test_name    (cur_name),
        .tests_done   (tests_done),
        .error_count  (error_count),
        .pending      (pending)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic set_row(input int idx, input logic [127:0] name, input int wid,
                           input gpu_op_e op, input logic [`NUM_THREADS-1:0] tmask,
                           input logic [`NUM_THREADS-1:0][31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] pc);
        rows[idx].name    = name;
        rows[idx].wid     = `NW_BITS'(wid);
        rows[idx].op      = op;
        rows[idx].tmask   = tmask;
        rows[idx].rs1     = rs1;
        rows[idx].rs2     = rs2;
        rows[idx].pc      = pc;
        rows[idx].next_pc = pc + 32'd4;
    endtask

    // rs1 lane 0 is the low word, split takes bit 0 of each lane
    task automatic load_table();
        set_row(0,  "tmc_cnt2",        0, GPU_TMC,    4'hf, 128'd2,     32'd0,   32'h100);
        set_row(1,  "wspawn_cnt4",     0, GPU_WSPAWN, 4'h3, 128'd4,     32'h200, 32'h104);
        set_row(2,  "split_diverge",   0, GPU_SPLIT,  4'h3, 128'd1,     32'd0,   32'h108);
        set_row(3,  "split_uniform",   0, GPU_SPLIT,  4'h1, {4{32'd0}}, 32'd0,   32'h10c);
        set_row(4,  "bar1_w0_wait",    0, GPU_BAR,    4'h1, 128'd1,     32'd3,   32'h110);
        set_row(5,  "bar1_w1_wait",    1, GPU_BAR,    4'hf, 128'd1,     32'd3,   32'h200);
        set_row(6,  "bar1_w2_release", 2, GPU_BAR,    4'hf, 128'd1,     32'd3,   32'h200);
        set_row(7,  "tmc_zero_w0",     0, GPU_TMC,    4'h1, 128'd0,     32'd0,   32'h114);
        set_row(8,  "tmc_cnt3_w1",     1, GPU_TMC,    4'hf, 128'd3,     32'd0,   32'h204);
        set_row(9,  "bar2_w3_wait",    3, GPU_BAR,    4'hf, 128'd2,     32'd2,   32'h200);
        set_row(10, "bar2_w2_release", 2, GPU_BAR,    4'hf, 128'd2,     32'd2,   32'h204);
        set_row(11, "tmc_zero_w1",     1, GPU_TMC,    4'h7, 128'd0,     32'd0,   32'h208);
    endtask

    task automatic drive_row(input row_t row);
        gpu_req_t r;
        r.valid   = 1'b1;
        r.wid     = row.wid;
        r.tmask   = row.tmask;
        r.pc      = row.pc;
        r.next_pc = row.next_pc;
        r.op      = row.op;
        r.rs1     = row.rs1;
        r.rs2     = row.rs2;
        req      <= r;
        cur_name <= row.name;
    endtask

    initial begin
        req      = '0;
        cur_name = '0;
        load_table();
        do @(posedge clk); while (!rst_n);
        for (int r = 0; r < NUM_ROWS; r++) begin
            drive_row(rows[r]);
            // taken on the first edge that sees req_ready
            do @(posedge clk); while (!req_ready);
            req.valid <= 1'b0;
            do @(posedge clk); while (!(commit.valid && commit_ready));
            @(posedge clk);
        end
        @(posedge clk);
        $display("tests %0d of %0d, errors %0d, commits left %0d",
                 tests_done, NUM_ROWS, error_count, pending);
        if (error_count == 0 && tests_done == NUM_ROWS && pending == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // commit_ready low only when both bits are zero
    always @(posedge clk) begin
        lfsr          = lfsr_next(lfsr);
        ready_bits[0] = lfsr[0];
        lfsr          = lfsr_next(lfsr);
        ready_bits[1] = lfsr[0];
        commit_ready <= |ready_bits;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not finish the table within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

endmodule

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module tb_checker import gpu_types_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gpu_req_t                req,
    input  logic                    req_ready,
    input  gpu_commit_t             commit,
    input  logic                    commit_ready,
    input  logic [`NUM_WARPS-1:0]   schedulable,
    input  logic                    sched_valid,
    input  logic [`NW_BITS-1:0]     sched_wid,
    input  logic [`NUM_THREADS-1:0] sched_tmask,
    input  logic [31:0]             sched_pc,
    input  logic [127:0]            test_name,
    output int                      tests_done,
    output int                      error_count,
    output int                      pending
);

    typedef struct packed {
        logic [127:0] name;
        gpu_req_t     req;
    } item_t;

    item_t                                   pend_q[$];
    item_t                                   acc;
    item_t                                   cur;
    gpu_commit_t                             held;
    logic                                    held_vld;
    logic                                    acc_last;
    logic                                    cmp_due;
    int                                      base_errs;
    // reference warp state
    logic [`NUM_WARPS-1:0]                   m_active;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] m_tmask;
    logic [`NUM_WARPS-1:0][31:0]             m_pc;
    int                                      m_count [`NUM_BARRIERS];
    logic [`NUM_WARPS-1:0]                   m_wait [`NUM_BARRIERS];

    task automatic check_val(input logic [127:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %0s %0s expected 0x%0h actual 0x%0h", name, what, exp, act);
            error_count++;
        end
    endtask

    task automatic apply_item(input gpu_req_t r);
        logic [`NUM_THREADS-1:0] taken;
        int                      b;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            taken[i] = r.rs1[i].count[0];
        end
        b = int'(r.rs1[0].bar.id);
        case (r.op)
            GPU_TMC: begin
                for (int i = 0; i < `NUM_THREADS; i++) begin
                    m_tmask[r.wid][i] = (i < r.rs1[0].count);
                end
                m_active[r.wid] = |m_tmask[r.wid];
            end
            GPU_WSPAWN: begin
                for (int w = 0; w < `NUM_WARPS; w++) begin
                    if (w < r.rs1[0].count && w != int'(r.wid)) begin
                        m_active[w] = 1'b1;
                        m_tmask[w]  = '1;
                        m_pc[w]     = r.rs2;
                    end
                end
            end
            // narrows only when lanes go both ways
            GPU_SPLIT: begin
                if (|(r.tmask & taken) && |(r.tmask & ~taken)) begin
                    m_tmask[r.wid] = r.tmask & taken;
                end
            end
            default: begin
                if (m_count[b] + 1 == int'(r.rs2)) begin
                    m_count[b] = 0;
                    m_wait[b]  = '0;
                end else begin
                    m_count[b]       += 1;
                    m_wait[b][r.wid] = 1'b1;
                end
            end
        endcase
    endtask

    task automatic compare_sched(input item_t it);
        logic [`NUM_WARPS-1:0] waiting;
        logic [`NUM_WARPS-1:0] exp_sched;
        int                    exp_wid;
        waiting = '0;
        for (int b = 0; b < `NUM_BARRIERS; b++) begin
            waiting |= m_wait[b];
        end
        exp_sched = m_active & ~waiting;
        exp_wid   = 0;
        while (exp_wid < `NUM_WARPS - 1 && !exp_sched[exp_wid]) begin
            exp_wid++;
        end
        if (exp_sched == '0) begin
            exp_wid = 0;
        end
        check_val(it.name, "schedulable", 32'(exp_sched), 32'(schedulable));
        check_val(it.name, "sched_valid", 32'(|exp_sched), 32'(sched_valid));
        check_val(it.name, "sched_wid", 32'(exp_wid), 32'(sched_wid));
        check_val(it.name, "sched_tmask", 32'(m_tmask[exp_wid]), 32'(sched_tmask));
        check_val(it.name, "sched_pc", m_pc[exp_wid], sched_pc);
        tests_done++;
        if (error_count == base_errs) begin
            $display("PASS %0s", it.name);
        end else begin
            $display("FAIL %0s with %0d errors", it.name, error_count - base_errs);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            m_active = `NUM_WARPS'(1);
            m_tmask  = '0;
            m_tmask[0] = '1;
            m_pc     = '0;
            for (int b = 0; b < `NUM_BARRIERS; b++) begin
                m_count[b] = 0;
                m_wait[b]  = '0;
            end
            pend_q.delete();
            held_vld    = 1'b0;
            acc_last    = 1'b0;
            cmp_due     = 1'b0;
            tests_done  = 0;
            error_count = 0;
            base_errs   = 0;
        end else begin
            if (req_ready !== !(commit.valid && !commit_ready)) begin
                $display("req_ready does not follow the commit stall at %0t", $time);
                error_count++;
            end
            if (held_vld && commit !== held) begin
                $display("commit changed while commit_ready was low at %0t", $time);
                error_count++;
            end
            if (acc_last && !commit.valid) begin
                $display("no commit one cycle after an accepted request at %0t", $time);
                error_count++;
            end
            held_vld = commit.valid && !commit_ready;
            held     = commit;
            if (cmp_due) begin
                compare_sched(cur);
                cmp_due = 1'b0;
            end
            if (commit.valid && commit_ready) begin
                if (pend_q.size() == 0) begin
                    $display("commit fired with no accepted request at %0t", $time);
                    error_count++;
                end else begin
                    cur = pend_q.pop_front();
                    check_val(cur.name, "commit wid", 32'(cur.req.wid), 32'(commit.wid));
                    check_val(cur.name, "commit tmask", 32'(cur.req.tmask), 32'(commit.tmask));
                    check_val(cur.name, "commit pc", cur.req.pc, commit.pc);
                    apply_item(cur.req);
                    cmp_due = 1'b1;
                end
            end
            acc_last = req.valid && req_ready;
            if (acc_last) begin
                acc.name  = test_name;
                acc.req   = req;
                pend_q.push_back(acc);
                base_errs = error_count;
            end
        end
        pending = pend_q.size();
    end

endmodule

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // release on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== gpu_ctl_top.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module gpu_ctl_top import gpu_types_pkg::*, warp_ctl_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  gpu_req_t                req,
    output logic                    req_ready,
    output gpu_commit_t             commit,
    input  logic                    commit_ready,
    output logic [`NUM_WARPS-1:0]   schedulable,
    output logic                    sched_valid,
    output logic [`NW_BITS-1:0]     sched_wid,
    output logic [`NUM_THREADS-1:0] sched_tmask,
    output logic [31:0]             sched_pc
);

    warp_ctl_t                               warp_ctl;
    logic [`NUM_WARPS-1:0]                   active_warps;
    logic [`NUM_WARPS-1:0]                   waiting_warps;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] warp_tmask;
    logic [`NUM_WARPS-1:0][31:0]             warp_pc;

    gpu_unit i_gpu_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_ready    (req_ready),
        .commit       (commit),
        .commit_ready (commit_ready),
        .warp_ctl     (warp_ctl)
    );

    // both tables see the same commit broadcast
    warp_mask_table i_warp_mask_table (
        .clk          (clk),
        .rst_n        (rst_n),
        .warp_ctl     (warp_ctl),
        .active_warps (active_warps),
        .warp_tmask   (warp_tmask),
        .warp_pc      (warp_pc)
    );

    barrier_table i_barrier_table (
        .clk           (clk),
        .rst_n         (rst_n),
        .warp_ctl      (warp_ctl),
        .waiting_warps (waiting_warps)
    );

    warp_sched i_warp_sched (
        .active_warps  (active_warps),
        .waiting_warps (waiting_warps),
        .warp_tmask    (warp_tmask),
        .warp_pc       (warp_pc),
        .schedulable   (schedulable),
        .sched_valid   (sched_valid),
        .sched_wid     (sched_wid),
        .sched_tmask   (sched_tmask),
        .sched_pc      (sched_pc)
    );

endmodule

// ==== warp_sched.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module warp_sched (
    input  logic [`NUM_WARPS-1:0]                   active_warps,
    input  logic [`NUM_WARPS-1:0]                   waiting_warps,
    input  logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] warp_tmask,
    input  logic [`NUM_WARPS-1:0][31:0]             warp_pc,
    output logic [`NUM_WARPS-1:0]                   schedulable,
    output logic                                    sched_valid,
    output logic [`NW_BITS-1:0]                     sched_wid,
    output logic [`NUM_THREADS-1:0]                 sched_tmask,
    output logic [31:0]                             sched_pc
);

    assign schedulable = active_warps & ~waiting_warps;
    assign sched_valid = |schedulable;

    // fixed priority, lowest id wins
    always_comb begin
        sched_wid = '0;
        for (int i = `NUM_WARPS - 1; i >= 0; i--) begin
            if (schedulable[i]) begin
                sched_wid = `NW_BITS'(i);
            end
        end
    end

    assign sched_tmask = warp_tmask[sched_wid];
    assign sched_pc    = warp_pc[sched_wid];

endmodule

// ==== barrier_table.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module barrier_table import warp_ctl_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  warp_ctl_t             warp_ctl,
    output logic [`NUM_WARPS-1:0] waiting_warps
);

    // arrivals still waiting, per barrier
    logic [`NUM_BARRIERS-1:0][`NW_BITS-1:0]  count_q;
    logic [`NUM_BARRIERS-1:0][`NUM_WARPS-1:0] wait_q;
    logic                                     bar_fire;
    logic [`NB_BITS-1:0]                      bar_id;
    logic                                     bar_release;

    assign bar_fire = warp_ctl.valid && warp_ctl.barrier.valid;
    assign bar_id   = warp_ctl.barrier.id;

    // size_m1 warps already parked means this arrival completes the set
    assign bar_release = (count_q[bar_id] == warp_ctl.barrier.size_m1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= '0;
            wait_q  <= '0;
        end else if (bar_fire) begin
            if (bar_release) begin
                count_q[bar_id] <= '0;
                wait_q[bar_id]  <= '0;
            end else begin
                count_q[bar_id]               <= count_q[bar_id] + `NW_BITS'(1);
                wait_q[bar_id][warp_ctl.wid]  <= 1'b1;
            end
        end
    end

    always_comb begin
        waiting_warps = '0;
        for (int b = 0; b < `NUM_BARRIERS; b++) begin
            waiting_warps = waiting_warps | wait_q[b];
        end
    end

    // a parked warp cannot issue a second bar
    for (genvar w = 0; w < `NUM_WARPS; w++) begin : g_chk
        logic [`NUM_BARRIERS-1:0] member;

        for (genvar b = 0; b < `NUM_BARRIERS; b++) begin : g_col
            assign member[b] = wait_q[b][w];
        end

        a_one_barrier: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(member));
    end

endmodule

// ==== warp_mask_table.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module warp_mask_table import warp_ctl_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  warp_ctl_t                              warp_ctl,
    output logic [`NUM_WARPS-1:0]                  active_warps,
    output logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] warp_tmask,
    output logic [`NUM_WARPS-1:0][31:0]            warp_pc
);

    logic [`NUM_WARPS-1:0]                   active_q;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] tmask_q;
    logic [`NUM_WARPS-1:0][31:0]             pc_q;
    logic                                    tmc_fire;
    logic                                    wspawn_fire;
    logic                                    split_fire;

    assign tmc_fire    = warp_ctl.valid && warp_ctl.tmc.valid;
    assign wspawn_fire = warp_ctl.valid && warp_ctl.wspawn.valid;
    // uniform splits leave the mask alone
    assign split_fire  = warp_ctl.valid && warp_ctl.split.valid && warp_ctl.split.diverged;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // only warp 0 runs out of reset
            active_q <= `NUM_WARPS'(1);
            for (int i = 0; i < `NUM_WARPS; i++) begin
                tmask_q[i] <= (i == 0) ? {`NUM_THREADS{1'b1}} : '0;
                pc_q[i]    <= 32'd0;
            end
        end else begin
            if (tmc_fire) begin
                tmask_q[warp_ctl.wid]  <= warp_ctl.tmc.tmask;
                active_q[warp_ctl.wid] <= |warp_ctl.tmc.tmask;
            end

            if (wspawn_fire) begin
                for (int i = 0; i < `NUM_WARPS; i++) begin
                    // the spawning warp keeps its own state
                    if (warp_ctl.wspawn.wmask[i] && (`NW_BITS'(i) != warp_ctl.wid)) begin
                        active_q[i] <= 1'b1;
                        tmask_q[i]  <= {`NUM_THREADS{1'b1}};
                        pc_q[i]     <= warp_ctl.wspawn.pc;
                    end
                end
            end

            // else side is not kept without the ipdom stack
            if (split_fire) begin
                tmask_q[warp_ctl.wid] <= warp_ctl.split.then_mask;
            end
        end
    end

    assign active_warps = active_q;
    assign warp_tmask   = tmask_q;
    assign warp_pc      = pc_q;

    for (genvar w = 0; w < `NUM_WARPS; w++) begin : g_chk
        a_active_has_lanes: assert property (@(posedge clk) disable iff (!rst_n)
            active_q[w] |-> (|tmask_q[w]));
    end

endmodule

// ==== gpu_unit.sv ====
`timescale 1ns/1ps
`include "gpu_params.svh"

module gpu_unit import gpu_types_pkg::*, warp_ctl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  gpu_req_t    req,
    output logic        req_ready,
    output gpu_commit_t commit,
    input  logic        commit_ready,
    output warp_ctl_t   warp_ctl
);

    logic                    stall;
    logic                    fire;
    logic [`NUM_THREADS-1:0] taken;
    logic [`NUM_THREADS-1:0] then_mask;
    logic [`NUM_THREADS-1:0] else_mask;
    gpu_commit_t             commit_d;
    gpu_commit_t             commit_q;
    warp_ctl_t               ctl_d;
    warp_ctl_t               ctl_q;

    for (genvar i = 0; i < `NUM_THREADS; i++) begin : g_taken
        assign taken[i] = req.rs1[i].count[0];
    end

    assign then_mask = req.tmask & taken;
    assign else_mask = req.tmask & ~taken;

    always_comb begin
        commit_d.valid = req.valid;
        commit_d.wid   = req.wid;
        commit_d.tmask = req.tmask;
        commit_d.pc    = req.pc;

        ctl_d.valid = req.valid;
        ctl_d.wid   = req.wid;

        // lanes below the count stay on
        ctl_d.tmc.valid = (req.op == GPU_TMC);
        for (int i = 0; i < `NUM_THREADS; i++) begin
            ctl_d.tmc.tmask[i] = (32'(i) < req.rs1[0].count);
        end

        ctl_d.wspawn.valid = (req.op == GPU_WSPAWN);
        for (int i = 0; i < `NUM_WARPS; i++) begin
            ctl_d.wspawn.wmask[i] = (32'(i) < req.rs1[0].count);
        end
        ctl_d.wspawn.pc = req.rs2;

        ctl_d.split.valid     = (req.op == GPU_SPLIT);
        ctl_d.split.diverged  = (|then_mask) && (|else_mask);
        ctl_d.split.then_mask = then_mask;
        ctl_d.split.else_mask = else_mask;
        ctl_d.split.pc        = req.next_pc;

        ctl_d.barrier.valid   = (req.op == GPU_BAR);
        ctl_d.barrier.id      = req.rs1[0].bar.id;
        ctl_d.barrier.size_m1 = `NW_BITS'(req.rs2 - 32'd1);
    end

    assign stall     = commit_q.valid && !commit_ready;
    assign fire      = commit_q.valid && commit_ready;
    assign req_ready = !stall;

    // one slot, held while the commit side stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            commit_q.valid <= 1'b0;
            ctl_q.valid    <= 1'b0;
        end else if (!stall) begin
            commit_q <= commit_d;
            ctl_q    <= ctl_d;
        end
    end

    assign commit = commit_q;

    always_comb begin
        warp_ctl       = ctl_q;
        warp_ctl.valid = fire;
    end

endmodule

// ==== warp_ctl_pkg.sv ====
`include "gpu_params.svh"

package warp_ctl_pkg;

    typedef struct packed {
        logic                    valid;
        logic [`NUM_THREADS-1:0] tmask;
    } tmc_t;

    typedef struct packed {
        logic                  valid;
        logic [`NUM_WARPS-1:0] wmask;
        logic [31:0]           pc;
    } wspawn_t;

    typedef struct packed {
        logic                    valid;
        logic                    diverged;
        logic [`NUM_THREADS-1:0] then_mask;
        logic [`NUM_THREADS-1:0] else_mask;
        logic [31:0]             pc;
    } split_t;

    typedef struct packed {
        logic                valid;
        logic [`NB_BITS-1:0] id;
        logic [`NW_BITS-1:0] size_m1;
    } barrier_t;

    // broadcast to the warp tables on commit
    typedef struct packed {
        logic                valid;
        logic [`NW_BITS-1:0] wid;
        tmc_t                tmc;
        wspawn_t             wspawn;
        split_t              split;
        barrier_t            barrier;
    } warp_ctl_t;

endpackage

// ==== gpu_types_pkg.sv ====
`include "gpu_params.svh"

package gpu_types_pkg;

    typedef enum logic [1:0] {
        GPU_TMC    = 2'd0,
        GPU_WSPAWN = 2'd1,
        GPU_SPLIT  = 2'd2,
        GPU_BAR    = 2'd3
    } gpu_op_e;

    // barrier view of the lane-0 operand
    typedef struct packed {
        logic [31-`NB_BITS:0] rsvd;
        logic [`NB_BITS-1:0]  id;
    } gpu_bar_arg_t;

    // lane-0 rs1, a count for tmc/wspawn or a barrier id for bar
    typedef union packed {
        logic [31:0]  count;
        gpu_bar_arg_t bar;
    } gpu_arg_u;

    typedef struct packed {
        logic                                valid;
        logic [`NW_BITS-1:0]                 wid;
        logic [`NUM_THREADS-1:0]             tmask;
        logic [31:0]                         pc;
        logic [31:0]                         next_pc;
        gpu_op_e                             op;
        // bit 0 of each lane is the split taken flag
        gpu_arg_u [`NUM_THREADS-1:0]         rs1;
        logic [31:0]                         rs2;
    } gpu_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`NW_BITS-1:0]     wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [31:0]             pc;
    } gpu_commit_t;

endpackage

// ==== gpu_params.svh ====
`ifndef GPU_PARAMS_SVH
`define GPU_PARAMS_SVH

// lanes per warp
`define NUM_THREADS 4

// warps per core
`define NUM_WARPS 4

// hardware barriers
`define NUM_BARRIERS 4

// warp id width, clog2 of NUM_WARPS
`define NW_BITS 2

// barrier id width, clog2 of NUM_BARRIERS
`define NB_BITS 2

`endif
